// ==== hdl/dcache_macros.svh ====
/*
 * Size constants of the data cache lookup port.
 * The design is only checked at these values.
 */

`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Associativity and number of sets
`define DCACHE_WAYS 4
`define DCACHE_SETS 16

// One 32-bit word per line
`define DCACHE_WORD_BITS 32

// Word address is split into tag (high bits) and set index (low bits)
`define DCACHE_ADDR_BITS 12
`define DCACHE_INDEX_BITS 4
`define DCACHE_TAG_BITS 8

// Width of a way number, log2 of the way count
`define DCACHE_WAY_IDX_BITS 2

`endif

// ==== hdl/dcache_pkg.sv ====
/*
 * Shared types of the data cache lookup port.
 * Widths come from the size macros and must stay consistent with them.
 */

`include "dcache_macros.svh"

package dcache_pkg;

    // Word address as seen on the read and refill ports
    typedef logic [`DCACHE_ADDR_BITS-1:0] addr_t;

    // Set index, the low bits of an address
    typedef logic [`DCACHE_INDEX_BITS-1:0] index_t;

    // Tag, the high bits of an address
    typedef logic [`DCACHE_TAG_BITS-1:0] tag_t;

    // Data word held by one line
    typedef logic [`DCACHE_WORD_BITS-1:0] word_t;

    // One bit per way
    // Used for valid bits, hit vectors and one-hot fill selects
    typedef logic [`DCACHE_WAYS-1:0] way_mask_t;

    // Number of a single way
    typedef logic [`DCACHE_WAY_IDX_BITS-1:0] way_idx_t;

endpackage : dcache_pkg

// ==== hdl/dcache_way_ram.sv ====
/*
 * Storage of one way, one entry per set, registered read.
 * A write is seen only by reads issued on later edges.
 * Contents have no reset and are meaningful only under a set valid bit.
 */

`include "dcache_macros.svh"

module dcache_way_ram #(
    parameter type payload_t = dcache_pkg::word_t
) (
    input  logic                 clk_i,

    // Read side with its result on the next edge
    input  dcache_pkg::index_t   rd_index_i,
    output payload_t             rd_payload_o,

    // Write side
    input  logic                 wr_i,
    input  dcache_pkg::index_t   wr_index_i,
    input  payload_t             wr_payload_i
);

    // --------------------
    // Storage array
    // --------------------

    // One payload per set
    payload_t mem_q [`DCACHE_SETS];

    // --------------------
    // Access
    // --------------------

    // Both ports work on the same edge
    // The read samples the array before the write lands, so a read and a
    // write to the same entry on one edge return the old payload
    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            mem_q[wr_index_i] <= wr_payload_i;
        end

        // The read register updates every cycle; its consumer qualifies it
        rd_payload_o <= mem_q[rd_index_i];
    end

endmodule : dcache_way_ram

// ==== hdl/dcache_hit_check.sv ====
/*
 * Tag comparison across all ways and selection of the hitting word.
 * At most one way may hit; this relies on the user never refilling
 * a line that is already present.
 */

`include "dcache_macros.svh"

module dcache_hit_check (
    // Registered outputs of the way memories
    input  dcache_pkg::tag_t  [`DCACHE_WAYS-1:0] way_tag_i,
    input  dcache_pkg::word_t [`DCACHE_WAYS-1:0] way_data_i,

    // Valid bits of the looked-up set and the tag being searched
    input  dcache_pkg::way_mask_t                way_valid_i,
    input  dcache_pkg::tag_t                     addr_tag_i,

    output logic                                 hit_o,
    output dcache_pkg::way_mask_t                way_hit_o,
    output dcache_pkg::word_t                    data_o
);

    // --------------------
    // Comparison
    // --------------------

    // Number of the way whose word goes out
    dcache_pkg::way_idx_t hit_sel;

    always_comb begin
        way_hit_o = '0;
        hit_sel   = '0;

        // A way hits only if its entry is valid and the tags agree
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_hit_o[w] = way_valid_i[w] && (way_tag_i[w] == addr_tag_i);

            // Later ways override earlier ones, so the highest hit wins
            if (way_hit_o[w]) begin
                hit_sel = dcache_pkg::way_idx_t'(w);
            end
        end
    end

    // --------------------
    // Results
    // --------------------

    // Any way hitting makes the lookup a hit
    assign hit_o = |way_hit_o;

    // On a miss this is way 0's word and carries no meaning
    assign data_o = way_data_i[hit_sel];

endmodule : dcache_hit_check

// ==== hdl/dcache_victim_select.sv ====
/*
 * Chooses the lowest invalid way of the set for a refill, or the set's
 * round-robin pointer when every way is valid.
 * The fill mask is combinational and is valid whenever the inputs are.
 */

`include "dcache_macros.svh"

module dcache_victim_select (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Refill strobe and the set it targets
    input  logic                  fill_i,
    input  dcache_pkg::index_t    fill_index_i,

    // Flush clears every pointer and takes priority over a fill
    input  logic                  flush_i,

    // Valid bits of the set being refilled
    input  dcache_pkg::way_mask_t set_valid_i,

    // One-hot choice of the way to write
    output dcache_pkg::way_mask_t fill_way_o
);

    // --------------------
    // Pointer state
    // --------------------

    // One replacement pointer per set
    dcache_pkg::way_idx_t rr_ptr_q [`DCACHE_SETS];

    // Set has no free way left
    logic set_full;

    // Lowest-numbered invalid way
    dcache_pkg::way_idx_t first_free;

    // Way finally chosen
    dcache_pkg::way_idx_t victim;

    // --------------------
    // Victim choice
    // --------------------

    assign set_full = &set_valid_i;

    // Scan downwards so that the lowest free way is the last one kept
    always_comb begin
        first_free = '0;
        for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
            if (!set_valid_i[w]) begin
                first_free = dcache_pkg::way_idx_t'(w);
            end
        end
    end

    // A free way is always preferred over eviction
    assign victim = set_full ? rr_ptr_q[fill_index_i] : first_free;

    assign fill_way_o = dcache_pkg::way_mask_t'(1) << victim;

    // --------------------
    // Pointer update
    // --------------------

    // The pointer only moves when a full set actually loses a line
    // Wrap from the last way back to way 0 comes from the pointer width
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                rr_ptr_q[s] <= '0;
            end
        end else if (fill_i && set_full) begin
            rr_ptr_q[fill_index_i] <= rr_ptr_q[fill_index_i] + 1'b1;
        end
    end

endmodule : dcache_victim_select

// ==== hdl/dcache_port.sv ====
/*
 * Lookup port of a 4-way, 16-set data cache with one word per line.
 * Read results come one cycle after rd_i; misses are refilled by the user.
 * Never refill a line that is already present; duplicates are not detected.
 */

`include "dcache_macros.svh"

module dcache_port (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Read lookup
    input  logic                  rd_i,
    input  dcache_pkg::addr_t     rd_addr_i,

    // Refill of a missing line
    input  logic                  fill_i,
    input  dcache_pkg::addr_t     fill_addr_i,
    input  dcache_pkg::word_t     fill_data_i,

    // Invalidate the whole cache
    input  logic                  flush_i,

    // The lookup result is valid while rd_done_o is high
    output logic                  rd_done_o,
    output logic                  hit_o,
    output dcache_pkg::way_mask_t way_hit_o,
    output dcache_pkg::word_t     rd_data_o
);

    // --------------------
    // Address fields
    // --------------------

    dcache_pkg::index_t rd_index;
    dcache_pkg::tag_t   rd_tag;
    dcache_pkg::index_t fill_index;
    dcache_pkg::tag_t   fill_tag;

    // Index sits in the low bits, tag in the high bits
    assign rd_index   = rd_addr_i[`DCACHE_INDEX_BITS-1:0];
    assign rd_tag     = rd_addr_i[`DCACHE_ADDR_BITS-1:`DCACHE_INDEX_BITS];
    assign fill_index = fill_addr_i[`DCACHE_INDEX_BITS-1:0];
    assign fill_tag   = fill_addr_i[`DCACHE_ADDR_BITS-1:`DCACHE_INDEX_BITS];

    // --------------------
    // Valid bits
    // --------------------

    // One valid bit per way in every set
    dcache_pkg::way_mask_t valid_q [`DCACHE_SETS];

    // One-hot way chosen for the current refill
    dcache_pkg::way_mask_t fill_way;

    // A flush drops a refill that arrives in the same cycle
    logic fill_en;

    // Per-way write enables for tag and data memories
    dcache_pkg::way_mask_t fill_we;

    assign fill_en = fill_i && !flush_i;
    assign fill_we = fill_way & {`DCACHE_WAYS{fill_en}};

    // The chosen way becomes valid at the fill edge
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (fill_en) begin
            valid_q[fill_index] <= valid_q[fill_index] | fill_way;
        end
    end

    dcache_victim_select victim_select_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .fill_i       (fill_i),
        .fill_index_i (fill_index),
        .flush_i      (flush_i),
        .set_valid_i  (valid_q[fill_index]),
        .fill_way_o   (fill_way)
    );

    // --------------------
    // Way memories
    // --------------------

    dcache_pkg::tag_t  [`DCACHE_WAYS-1:0] way_tag;
    dcache_pkg::word_t [`DCACHE_WAYS-1:0] way_data;

    // Every way reads the same set; only the victim way is written
    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        dcache_way_ram #(
            .payload_t (dcache_pkg::tag_t)
        ) tag_ram_inst (
            .clk_i        (clk_i),
            .rd_index_i   (rd_index),
            .rd_payload_o (way_tag[w]),
            .wr_i         (fill_we[w]),
            .wr_index_i   (fill_index),
            .wr_payload_i (fill_tag)
        );

        dcache_way_ram #(
            .payload_t (dcache_pkg::word_t)
        ) data_ram_inst (
            .clk_i        (clk_i),
            .rd_index_i   (rd_index),
            .rd_payload_o (way_data[w]),
            .wr_i         (fill_we[w]),
            .wr_index_i   (fill_index),
            .wr_payload_i (fill_data_i)
        );
    end

    // --------------------
    // Read stage
    // --------------------

    logic                  rd_done_q;
    dcache_pkg::way_mask_t rd_valid_q;
    dcache_pkg::tag_t      rd_tag_q;

    // Snapshot is taken before any same-edge fill or flush lands,
    // which matches the old contents read out of the memories
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_done_q  <= 1'b0;
            rd_valid_q <= '0;
        end else begin
            rd_done_q <= rd_i;
            if (rd_i) begin
                rd_valid_q <= valid_q[rd_index];
            end
        end
    end

    // Tag under lookup, meaningful only alongside rd_done_q
    always_ff @(posedge clk_i) begin
        if (rd_i) begin
            rd_tag_q <= rd_tag;
        end
    end

    assign rd_done_o = rd_done_q;

    dcache_hit_check hit_check_inst (
        .way_tag_i   (way_tag),
        .way_data_i  (way_data),
        .way_valid_i (rd_valid_q),
        .addr_tag_i  (rd_tag_q),
        .hit_o       (hit_o),
        .way_hit_o   (way_hit_o),
        .data_o      (rd_data_o)
    );

endmodule : dcache_port

// ==== dv/dcache_properties.sv ====
/*
 * Concurrent checks bound into the cache lookup port.
 * Covers read result timing and the shape of the hit vector only.
 */

`include "dcache_macros.svh"

module dcache_properties (
    input logic                  clk_i,
    input logic                  rst_i,
    input logic                  rd_i,
    input logic                  rd_done_i,
    input logic                  hit_i,
    input dcache_pkg::way_mask_t way_hit_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // --------------------
    // Read timing
    // --------------------

    // The result strobe is the read strobe one edge later
    done_follows_read: assert property (@(posedge clk_i) disable iff (rst_i)
        rd_done_i == $past(rd_i))
        else $error("rd_done_o does not follow rd_i by one cycle");

    // No stale result survives a reset
    done_low_after_reset: assert property (@(posedge clk_i)
        rst_i |=> !rd_done_i)
        else $error("rd_done_o high in the cycle after reset");

    // --------------------
    // Hit vector
    // --------------------

    // Only one way may hold a given line
    way_hit_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        rd_done_i |-> $onehot0(way_hit_i))
        else $error("way_hit_o has more than one bit set");

    hit_matches_vector: assert property (@(posedge clk_i) disable iff (rst_i)
        hit_i == (way_hit_i != '0))
        else $error("hit_o disagrees with way_hit_o");

endmodule : dcache_properties

bind dcache_port dcache_properties dcache_properties_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rd_i      (rd_i),
    .rd_done_i (rd_done_o),
    .hit_i     (hit_o),
    .way_hit_i (way_hit_o)
);

// ==== dv/dcache_tb.sv ====
/*
 * Directed and random tests of the cache lookup port against a reference model.
 * Each read is checked in the cycle after it is issued.
 * Random fills never target a line the model already holds.
 */

`include "dcache_macros.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // Directed tests stay below this operation count
    localparam int DIRECTED_OPS = 80;
    localparam int RAND_OPS     = 300;

    logic                  clk_i;
    logic                  rst_i;
    logic                  rd_i;
    logic                  fill_i;
    logic                  flush_i;
    dcache_pkg::addr_t     rd_addr_i;
    dcache_pkg::addr_t     fill_addr_i;
    dcache_pkg::word_t     fill_data_i;
    logic                  rd_done_o;
    logic                  hit_o;
    dcache_pkg::way_mask_t way_hit_o;
    dcache_pkg::word_t     rd_data_o;

    int errors = 0;
    int checks = 0;

    // --------------------
    // Reference model
    // --------------------

    dcache_pkg::way_mask_t m_valid [`DCACHE_SETS];
    dcache_pkg::tag_t      m_tag   [`DCACHE_SETS][`DCACHE_WAYS];
    dcache_pkg::word_t     m_data  [`DCACHE_SETS][`DCACHE_WAYS];
    dcache_pkg::way_idx_t  m_ptr   [`DCACHE_SETS];

    // Expectation of the read issued in the previous cycle
    logic                  exp_rd = 1'b0;
    logic                  exp_hit;
    dcache_pkg::way_mask_t exp_way;
    dcache_pkg::word_t     exp_data;

    dcache_port dcache_port_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rd_i        (rd_i),
        .rd_addr_i   (rd_addr_i),
        .fill_i      (fill_i),
        .fill_addr_i (fill_addr_i),
        .fill_data_i (fill_data_i),
        .flush_i     (flush_i),
        .rd_done_o   (rd_done_o),
        .hit_o       (hit_o),
        .way_hit_o   (way_hit_o),
        .rd_data_o   (rd_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Every cycle costs 4 ns; a factor of 4 leaves plenty of slack
    initial begin
        #((DIRECTED_OPS + RAND_OPS) * 4 * 4 + 200);
        $display("Timeout: the tests did not finish in time");
        $display("Checks failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s actual 0x%0h expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    // Hit state of an address under the cache's lookup rules
    task automatic lookup_model(input dcache_pkg::addr_t addr, output logic hit,
                                output dcache_pkg::way_mask_t way, output dcache_pkg::word_t data);
        dcache_pkg::index_t idx;
        idx  = addr[3:0];
        way  = '0;
        data = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == addr[11:4]) begin
                way[w] = 1'b1;
                data   = m_data[idx][w];
            end
        end
        hit = |way;
    endtask

    // Flush wins over fill; a fill takes the first free way, else the pointer way
    task automatic update_model(input logic fill, input dcache_pkg::addr_t faddr,
                                input dcache_pkg::word_t fdata, input logic flush);
        dcache_pkg::index_t   idx;
        dcache_pkg::way_idx_t victim;
        logic                 found;
        idx    = faddr[3:0];
        victim = '0;
        found  = 1'b0;
        if (flush) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                m_valid[s] = '0;
                m_ptr[s]   = '0;
            end
        end else if (fill) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                if (!found && !m_valid[idx][w]) begin
                    victim = dcache_pkg::way_idx_t'(w);
                    found  = 1'b1;
                end
            end
            if (!found) begin
                victim     = m_ptr[idx];
                m_ptr[idx] = m_ptr[idx] + 2'd1;
            end
            m_valid[idx][victim] = 1'b1;
            m_tag[idx][victim]   = faddr[11:4];
            m_data[idx][victim]  = fdata;
        end
    endtask

    // --------------------
    // Cycle driver
    // --------------------

    // Drives one cycle and checks, at the falling edge, the read of the cycle before
    task automatic drive_cycle(input logic rd, input dcache_pkg::addr_t raddr,
                               input logic fill, input dcache_pkg::addr_t faddr,
                               input dcache_pkg::word_t fdata, input logic flush,
                               input logic ehit, input dcache_pkg::way_mask_t eway,
                               input dcache_pkg::word_t edata);
        @(posedge clk_i);
        rd_i        <= rd;
        rd_addr_i   <= raddr;
        fill_i      <= fill;
        fill_addr_i <= faddr;
        fill_data_i <= fdata;
        flush_i     <= flush;
        @(negedge clk_i);
        if (rd_done_o !== exp_rd) begin
            errors++;
            if (exp_rd) begin
                $display("At %0t rd_done_o was not high in the cycle after rd_i", $time);
            end else begin
                $display("At %0t rd_done_o was high with no read one cycle earlier", $time);
            end
        end else if (exp_rd) begin
            check_value("hit_o", 32'(hit_o), 32'(exp_hit));
            check_value("way_hit_o", 32'(way_hit_o), 32'(exp_way));
            // Data carries no meaning on a miss
            if (exp_hit) begin
                check_value("rd_data_o", rd_data_o, exp_data);
            end
        end
        exp_rd   = rd;
        exp_hit  = ehit;
        exp_way  = eway;
        exp_data = edata;
        update_model(fill, faddr, fdata, flush);
    endtask

    task automatic read_expect(input dcache_pkg::addr_t addr, input logic hit,
                               input int way, input dcache_pkg::word_t data);
        drive_cycle(1'b1, addr, 1'b0, '0, '0, 1'b0, hit,
                    dcache_pkg::way_mask_t'(hit ? (1 << way) : 0), data);
    endtask

    task automatic fill_line(input dcache_pkg::addr_t addr);
        drive_cycle(1'b0, '0, 1'b1, addr, data_for(addr), 1'b0, 1'b0, '0, '0);
    endtask

    task automatic flush_cache();
        drive_cycle(1'b0, '0, 1'b0, '0, '0, 1'b1, 1'b0, '0, '0);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0);
    endtask

    // Line contents that depend on the whole address
    function automatic dcache_pkg::word_t data_for(input dcache_pkg::addr_t addr);
        return {20'hC0DE0, addr};
    endfunction

    // --------------------
    // Tests
    // --------------------

    task automatic cold_miss();
        read_expect(12'h000, 1'b0, 0, '0);
        read_expect(12'h123, 1'b0, 0, '0);
        read_expect(12'hFFF, 1'b0, 0, '0);
        read_expect(12'h5A7, 1'b0, 0, '0);
        idle_cycles(2);
    endtask

    // Tags 0x10 to 0x13 in set 2 fill ways 0 to 3
    task automatic fill_and_hit();
        for (int w = 0; w < 4; w++) begin
            fill_line({8'h10 + 8'(w), 4'h2});
        end
        for (int w = 0; w < 4; w++) begin
            read_expect({8'h10 + 8'(w), 4'h2}, 1'b1, w, data_for({8'h10 + 8'(w), 4'h2}));
        end
        idle_cycles(2);
    endtask

    // Set 2 is full, so tags 0x14 and 0x15 evict ways 0 and 1
    task automatic round_robin_replace();
        fill_line(12'h142);
        fill_line(12'h152);
        read_expect(12'h102, 1'b0, 0, '0);
        read_expect(12'h112, 1'b0, 0, '0);
        read_expect(12'h122, 1'b1, 2, data_for(12'h122));
        read_expect(12'h132, 1'b1, 3, data_for(12'h132));
        read_expect(12'h142, 1'b1, 0, data_for(12'h142));
        read_expect(12'h152, 1'b1, 1, data_for(12'h152));
        idle_cycles(2);
    endtask

    // Set 6 advances its own pointer; set 2 still points at way 2 afterwards
    task automatic set_tag_independence();
        read_expect(12'h126, 1'b0, 0, '0);
        for (int w = 0; w < 5; w++) begin
            fill_line({8'h30 + 8'(w), 4'h6});
        end
        fill_line(12'h162);
        read_expect(12'h162, 1'b1, 2, data_for(12'h162));
        read_expect(12'h346, 1'b1, 0, data_for(12'h346));
        read_expect(12'h306, 1'b0, 0, '0);
        idle_cycles(2);
    endtask

    task automatic flush_all_lines();
        flush_cache();
        for (int t = 0; t < 7; t++) begin
            read_expect({8'h10 + 8'(t), 4'h2}, 1'b0, 0, '0);
        end
        fill_line(12'h773);
        read_expect(12'h773, 1'b1, 0, data_for(12'h773));
        fill_line(12'h142);
        read_expect(12'h142, 1'b1, 0, data_for(12'h142));
        // Set 6 held pointer 1 before the flush, so a cleared pointer evicts way 0
        for (int w = 0; w < 5; w++) begin
            fill_line({8'h40 + 8'(w), 4'h6});
        end
        read_expect(12'h446, 1'b1, 0, data_for(12'h446));
        read_expect(12'h406, 1'b0, 0, '0);
        idle_cycles(2);
    endtask

    // Eight tags over four sets keep evictions frequent
    task automatic random_traffic();
        logic [31:0]           r;
        dcache_pkg::addr_t     raddr;
        dcache_pkg::addr_t     faddr;
        logic                  present;
        logic                  ehit;
        dcache_pkg::way_mask_t eway;
        dcache_pkg::word_t     edata;
        flush_cache();
        for (int i = 0; i < RAND_OPS; i++) begin
            r     = $urandom;
            faddr = {5'b00100, r[2:0], 2'b00, r[4:3]};
            raddr = {5'b00100, r[7:5], 2'b00, r[9:8]};
            // Sometimes read the very line being filled in the same cycle
            if (r[11:10] == 2'd0) begin
                raddr = faddr;
            end
            lookup_model(faddr, present, eway, edata);
            lookup_model(raddr, ehit, eway, edata);
            drive_cycle(r[20:19] != 2'd0, raddr, r[12] && !present, faddr, $urandom,
                        r[18:13] == 6'd0, ehit, eway, edata);
        end
        idle_cycles(2);
    endtask

    initial begin
        void'($urandom(48232));
        rst_i       = 1'b1;
        rd_i        = 1'b0;
        rd_addr_i   = '0;
        fill_i      = 1'b0;
        fill_addr_i = '0;
        fill_data_i = '0;
        flush_i     = 1'b0;
        update_model(1'b0, '0, '0, 1'b1);
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;
        cold_miss();
        fill_and_hit();
        round_robin_replace();
        set_tag_independence();
        flush_all_lines();
        random_traffic();
        $display("Closing report: %0d errors in %0d value checks", errors, checks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : dcache_tb

// ==== dcache.f ====
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_way_ram.sv
hdl/dcache_hit_check.sv
hdl/dcache_victim_select.sv
hdl/dcache_port.sv
dv/dcache_properties.sv
dv/dcache_tb.sv

// ==== run_dcache.sh ====
#!/bin/sh
# Build the cache testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f dcache.f --top-module dcache_tb -Mdir obj_dir \
    && { ./obj_dir/Vdcache_tb > "$LOG" 2>&1 || true; } \
    && cat "$LOG" \
    && ! grep -q "Checks failed" "$LOG" \
    && grep -q "All checks passed" "$LOG" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
